//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Line geometry
`define DC_LINE_BITS 128
`define DC_SETS 2

// Address split widths
// Index bits must match log2 of the set count
`define DC_INDEX_BITS 1
`define DC_WORD_BITS 2 // log2 of 32-bit words per line

// Whatever is left above index, word and byte offset
`define DC_TAG_BITS (32 - `DC_INDEX_BITS - `DC_WORD_BITS - 2)

// Memory side flow control
`define DC_MEM_CREDITS 2
`define DC_CREDIT_BITS 2 // Wide enough to hold DC_MEM_CREDITS

`endif

//--- source/dcache_ctrl.sv
`include "dcache_cfg.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  dc_req_t                  req,
    output logic                     req_ready,
    output logic                     resp_valid,
    output dc_resp_t                 resp,
    input  lookup_t                  lookup,
    input  logic [`DC_LINE_BITS-1:0] victim_line,
    input  logic [31:0]              load_value,
    input  logic [31:0]              merged_word,
    input  logic                     has_credit,
    output logic                     consume,
    output logic                     mem_req_valid,
    output mem_req_t                 mem_req,
    input  logic                     mem_resp_valid,
    output logic                     word_we,
    output logic                     word_way,
    output logic [31:0]              word_data,
    output logic                     refill_we,
    output logic                     mark_dirty,
    output logic                     touch,
    output logic                     touch_way,
    output logic                     clean_victim,
    output dc_req_t                  held_req
);

    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL_REQ, REFILL_WAIT} state_t;

    state_t  state;
    logic    replay;  // Refilled request reruns as a hit
    dc_req_t held_q;
    logic    do_access;
    logic    do_hit;

    assign req_ready = (state == IDLE) && !replay;
    assign held_req  = req_ready ? req : held_q; // Live request only while idle
    assign do_access = replay || (req_valid && req_ready);
    assign do_hit    = do_access && lookup.hit;

    // Array strobes, all act on the next edge
    assign word_we      = do_hit && held_req.we;
    assign mark_dirty   = word_we;
    assign word_way     = lookup.hit_way;
    assign word_data    = merged_word;
    assign touch        = do_hit;
    assign touch_way    = lookup.hit_way;
    assign refill_we    = (state == REFILL_WAIT) && mem_resp_valid;
    assign clean_victim = (state == WRITEBACK) && has_credit;

    // One request per credit, never without one
    assign mem_req_valid = ((state == WRITEBACK) || (state == REFILL_REQ)) && has_credit;
    assign consume       = mem_req_valid;

    always_comb begin
        mem_req.write = (state == WRITEBACK);
        mem_req.wdata = victim_line;
        if (state == WRITEBACK) begin
            mem_req.addr = {lookup.victim_tag, held_q.addr.f.index,
                            {(`DC_WORD_BITS + 2){1'b0}}};
        end else begin
            mem_req.addr = {held_q.addr.f.tag, held_q.addr.f.index,
                            {(`DC_WORD_BITS + 2){1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            replay     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= do_hit;
            case (state)
                IDLE: begin
                    if (do_hit) begin
                        replay <= 1'b0;
                    end else if (do_access) begin
                        // Dirty victim goes out before the refill
                        state <= (lookup.victim_valid && lookup.victim_dirty) ?
                                 WRITEBACK : REFILL_REQ;
                    end
                end
                WRITEBACK:   if (has_credit) state <= REFILL_REQ;
                REFILL_REQ:  if (has_credit) state <= REFILL_WAIT;
                REFILL_WAIT: begin
                    if (mem_resp_valid) begin
                        state  <= IDLE;
                        replay <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            held_q <= req;
        end
        if (do_hit) begin
            resp.data <= held_req.we ? 32'd0 : load_value;
        end
    end

endmodule

//--- source/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    // Lookup view of a byte address
    typedef struct packed {
        logic [`DC_TAG_BITS-1:0]   tag;
        logic [`DC_INDEX_BITS-1:0] index;
        logic [`DC_WORD_BITS-1:0]  word;
        logic [1:0]                offset;
    } dc_addr_fields_t;

    typedef union packed {
        logic [31:0]     raw; // Transport view
        dc_addr_fields_t f;
    } dc_addr_u;

    typedef struct packed {
        dc_addr_u    addr;
        logic        we;
        logic [2:0]  funct3;
        logic [31:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic [31:0] data; // Zero for stores
    } dc_resp_t;

    typedef struct packed {
        logic                     write;
        logic [31:0]              addr;  // Line aligned
        logic [`DC_LINE_BITS-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`DC_LINE_BITS-1:0] line;
    } mem_resp_t;

    typedef struct packed {
        logic                    hit;
        logic                    hit_way;
        logic                    victim_way;
        logic                    victim_valid;
        logic                    victim_dirty;
        logic [`DC_TAG_BITS-1:0] victim_tag;
    } lookup_t;

    // RISC-V funct3, loads and stores share codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

endpackage

//--- source/dcache_store.sv
`include "dcache_cfg.svh"

module dcache_store
    import dcache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  dc_addr_u                 addr,
    output lookup_t                  lookup,
    output logic [`DC_LINE_BITS-1:0] hit_line,
    output logic [`DC_LINE_BITS-1:0] victim_line,
    input  logic                     word_we,
    input  logic                     word_way,
    input  logic [31:0]              word_data,
    input  logic                     refill_we,
    input  mem_resp_t                refill_line,
    input  logic                     mark_dirty,
    input  logic                     touch,
    input  logic                     touch_way,
    input  logic                     clean_victim
);

    logic [`DC_LINE_BITS-1:0] line_q  [`DC_SETS][2];
    logic [`DC_TAG_BITS-1:0]  tag_q   [`DC_SETS][2];
    logic [1:0]               valid_q [`DC_SETS];
    logic [1:0]               dirty_q [`DC_SETS];
    logic                     lru_q   [`DC_SETS]; // Least recently used way

    logic [`DC_INDEX_BITS-1:0] idx;
    logic [1:0]                way_match;
    logic                      victim;

    assign idx = addr.f.index;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = valid_q[idx][w] && (tag_q[idx][w] == addr.f.tag);
        end
    end

    // Empty way first, then the LRU one
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[idx];
        end
    end

    assign lookup.hit          = |way_match;
    assign lookup.hit_way      = way_match[1];
    assign lookup.victim_way   = victim;
    assign lookup.victim_valid = valid_q[idx][victim];
    assign lookup.victim_dirty = dirty_q[idx][victim];
    assign lookup.victim_tag   = tag_q[idx][victim];

    assign hit_line    = line_q[idx][way_match[1]];
    assign victim_line = line_q[idx][victim];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= 2'b00;
                dirty_q[s] <= 2'b00;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            if (refill_we) begin
                valid_q[idx][victim] <= 1'b1;
                dirty_q[idx][victim] <= 1'b0; // Fresh line from memory
            end
            if (clean_victim) begin
                dirty_q[idx][victim] <= 1'b0;
            end
            if (mark_dirty) begin
                dirty_q[idx][word_way] <= 1'b1;
            end
            if (touch) begin
                lru_q[idx] <= ~touch_way; // Other way ages
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            line_q[idx][victim] <= refill_line.line;
            tag_q[idx][victim]  <= addr.f.tag;
        end
        if (word_we) begin
            line_q[idx][word_way][{addr.f.word, 5'b0} +: 32] <= word_data;
        end
    end

endmodule

//--- source/dcache_top.sv
`include "dcache_cfg.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  dc_req_t   req,
    output logic      req_ready,
    output logic      resp_valid,
    output dc_resp_t  resp,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      credit_return,
    input  logic      mem_resp_valid,
    input  mem_resp_t mem_resp
);

    lookup_t                  lookup;
    dc_req_t                  held_req;
    logic [`DC_LINE_BITS-1:0] hit_line;
    logic [`DC_LINE_BITS-1:0] victim_line;
    logic [31:0]              load_value;
    logic [31:0]              merged_word;
    logic [31:0]              word_data;
    logic                     has_credit;
    logic                     consume;
    logic                     word_we;
    logic                     word_way;
    logic                     refill_we;
    logic                     mark_dirty;
    logic                     touch;
    logic                     touch_way;
    logic                     clean_victim;

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp(resp),
        .lookup(lookup), .victim_line(victim_line),
        .load_value(load_value), .merged_word(merged_word),
        .has_credit(has_credit), .consume(consume),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid),
        .word_we(word_we), .word_way(word_way), .word_data(word_data),
        .refill_we(refill_we), .mark_dirty(mark_dirty),
        .touch(touch), .touch_way(touch_way), .clean_victim(clean_victim),
        .held_req(held_req)
    );

    mem_credit_counter u_credits (
        .clk(clk), .reset(reset),
        .consume(consume), .credit_return(credit_return), .has_credit(has_credit)
    );

    // Store sees the live or held address chosen by the controller
    dcache_store u_store (
        .clk(clk), .reset(reset), .addr(held_req.addr),
        .lookup(lookup), .hit_line(hit_line), .victim_line(victim_line),
        .word_we(word_we), .word_way(word_way), .word_data(word_data),
        .refill_we(refill_we), .refill_line(mem_resp),
        .mark_dirty(mark_dirty), .touch(touch), .touch_way(touch_way),
        .clean_victim(clean_victim)
    );

    load_store_align u_align (
        .line(hit_line), .addr(held_req.addr), .funct3(held_req.funct3),
        .store_data(held_req.wdata),
        .load_value(load_value), .merged_word(merged_word)
    );

endmodule

//--- source/load_store_align.sv
`include "dcache_cfg.svh"

module load_store_align
    import dcache_pkg::*;
(
    input  logic [`DC_LINE_BITS-1:0] line,
    input  dc_addr_u                 addr,
    input  logic [2:0]               funct3,
    input  logic [31:0]              store_data,
    output logic [31:0]              load_value,
    output logic [31:0]              merged_word
);

    logic [31:0] word;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    assign word     = line[{addr.f.word, 5'b0} +: 32];
    assign byte_val = word[{addr.f.offset, 3'b0} +: 8];
    assign half_val = word[{addr.f.offset[1], 4'b0} +: 16]; // Aligned halfword

    always_comb begin
        case (funct3)
            F3_LB:   load_value = {{24{byte_val[7]}}, byte_val};
            F3_LH:   load_value = {{16{half_val[15]}}, half_val};
            F3_LW:   load_value = word;
            F3_LBU:  load_value = {24'd0, byte_val};
            F3_LHU:  load_value = {16'd0, half_val};
            default: load_value = word;
        endcase
    end

    // Store lanes land on top of the old word
    always_comb begin
        merged_word = word;
        case (funct3)
            F3_SB:   merged_word[{addr.f.offset, 3'b0} +: 8] = store_data[7:0];
            F3_SH:   merged_word[{addr.f.offset[1], 4'b0} +: 16] = store_data[15:0];
            F3_SW:   merged_word = store_data;
            default: merged_word = word;
        endcase
    end

endmodule

//--- source/mem_credit_counter.sv
`include "dcache_cfg.svh"

module mem_credit_counter (
    input  logic clk,
    input  logic reset,
    input  logic consume,
    input  logic credit_return,
    output logic has_credit
);

    localparam logic [`DC_CREDIT_BITS-1:0] MAX_CREDITS = `DC_CREDIT_BITS'(`DC_MEM_CREDITS);

    logic [`DC_CREDIT_BITS-1:0] count;

    // Saturates at both ends
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= MAX_CREDITS;
        end else if (consume && !credit_return) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
        end else if (credit_return && !consume) begin
            if (count != MAX_CREDITS) begin
                count <= count + 1'b1;
            end
        end
        // Both at once leaves the count alone
    end

    assign has_credit = (count != '0);

endmodule

//--- verif/dcache_assert.sv
module dcache_assert (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic req_ready,
    input logic resp_valid,
    input logic mem_req_valid,
    input logic has_credit,
    input logic in_idle
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] pending; // Accepted requests still owed a response

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 2'd0;
        end else if (req_valid && req_ready && !resp_valid) begin
            pending <= pending + 2'd1;
        end else if (resp_valid && !(req_valid && req_ready)) begin
            pending <= pending - 2'd1;
        end
    end

    // Memory request only while a credit is held
    a_credit: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> has_credit)
        else $error("memory request issued without a credit");

    // Every response answers an accepted request
    a_resp: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> pending != 2'd0)
        else $error("response without a preceding acceptance");

    // Busy states serve an open request and keep the core out
    a_ready: assert property (@(posedge clk) disable iff (reset)
        !in_idle |-> (!req_ready && pending != 2'd0))
        else $error("req_ready high outside IDLE or controller busy with no open request");

endmodule

//--- verif/dcache_tb.sv
`include "dcache_cfg.svh"

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LAT = 8;
    localparam int OPS = 520;
    localparam int WORST_CYCLES = 2 * (MAX_LAT + 3) + 4; // Writeback plus refill
    localparam int MARGIN = 3;
    localparam logic [31:0] SEED = 32'hb950b1f9;

    logic clk, reset, req_valid, req_ready, resp_valid;
    logic mem_req_valid, credit_return, mem_resp_valid;
    dc_req_t req;
    dc_resp_t resp;
    mem_req_t mem_req;
    mem_resp_t mem_resp;

    logic [7:0] ref_mem [logic [31:0]];
    logic [`DC_LINE_BITS-1:0] mem_lines [logic [31:0]];
    mem_req_t pend [$];
    logic [31:0] exp_q [$];
    int acc_q [$];
    logic [31:0] stim_rng = SEED; // Stimulus stream
    logic [31:0] lat_rng = SEED;  // Memory latency stream
    logic [31:0] last_wb_addr;
    int errors = 0, cycle = 0, held_reqs = 0, ready_while_held = 0, owed = 0;
    bit hold = 0, watch = 0, check_lat = 0;
    string test_name = "reset";

    dcache_top uut (.*);

    bind dcache_ctrl dcache_assert u_assert (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
        .resp_valid(resp_valid), .mem_req_valid(mem_req_valid),
        .has_credit(has_credit), .in_idle(state == IDLE)
    );

    initial begin
        clk = 0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // Backing contents depend on every address bit
    function automatic logic [7:0] pattern(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] ref_byte(logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : pattern(a);
    endfunction

    function automatic logic [31:0] ref_load(logic [31:0] a, logic [2:0] f3);
        logic [15:0] h;
        h = {ref_byte(a + 1), ref_byte(a)};
        case (f3)
            F3_LB:   return {{24{h[7]}}, h[7:0]};
            F3_LBU:  return {24'd0, h[7:0]};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LHU:  return {16'd0, h};
            default: return {ref_byte(a + 3), ref_byte(a + 2), h};
        endcase
    endfunction

    function automatic logic [`DC_LINE_BITS-1:0] read_line(logic [31:0] a);
        logic [`DC_LINE_BITS-1:0] l;
        if (mem_lines.exists(a)) return mem_lines[a];
        for (int i = 0; i < `DC_LINE_BITS / 8; i++) l[i*8 +: 8] = pattern(a + i);
        return l;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic issue(logic [31:0] a, logic we, logic [2:0] f3, logic [31:0] d);
        dc_req_t r;
        r.addr.raw = a;
        r.we = we;
        r.funct3 = f3;
        r.wdata = d;
        req_valid <= 1'b1;
        req <= r;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    // One credit pulse, with the line for a read
    task automatic send_credit(logic with_line, logic [`DC_LINE_BITS-1:0] line);
        credit_return <= 1'b1;
        mem_resp_valid <= with_line;
        mem_resp.line <= line;
        @(posedge clk);
        credit_return <= 1'b0;
        mem_resp_valid <= 1'b0;
    endtask

    // Memory model, one request at a time in arrival order
    always @(negedge clk) if (!reset && mem_req_valid) pend.push_back(mem_req);

    initial begin
        mem_req_t m;
        forever begin
            @(posedge clk);
            if (pend.size() != 0) begin
                m = pend.pop_front();
                lat_rng = xorshift(lat_rng);
                repeat (lat_rng % MAX_LAT) @(posedge clk);
                if (m.write) begin
                    mem_lines[m.addr] = m.wdata;
                    last_wb_addr = m.addr;
                end
                if (m.write && hold) begin
                    owed++; // Write credit kept back
                end else begin
                    send_credit(!m.write, read_line(m.addr));
                end
            end else if (owed != 0 && !hold) begin
                owed--;
                send_credit(1'b0, '0);
            end
        end
    end

    // Reference update at acceptance, compare at response
    always @(negedge clk) begin
        if (!reset) begin
            cycle++;
            if (watch && mem_req_valid) held_reqs++;
            if (watch && req_ready) ready_while_held++;
            if (req_valid && req_ready) begin
                exp_q.push_back(req.we ? 32'd0 : ref_load(req.addr.raw, req.funct3));
                acc_q.push_back(cycle);
                if (req.we) begin
                    for (int i = 0; i < (1 << req.funct3[1:0]); i++)
                        ref_mem[req.addr.raw + i] = req.wdata[i*8 +: 8];
                end
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response arrived with no request outstanding");
                end else begin
                    check(test_name, exp_q.pop_front(), resp.data);
                    if (check_lat) check({test_name, " latency"}, 1, cycle - acc_q[0]);
                    void'(acc_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(OPS * WORST_CYCLES * MARGIN * 8);
        $display("Timeout with %0d responses outstanding", exp_q.size());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] r, a;
        logic [2:0] f3;
        reset = 1;
        req_valid = 0;
        req = '0;
        credit_return = 0;
        mem_resp_valid = 0;
        mem_resp = '0;
        repeat (5) @(posedge clk);
        reset <= 0;
        @(posedge clk);

        test_name = "load widths";
        for (int i = 0; i < 16; i++) begin
            issue(i, 0, F3_LB, 0);
            issue(i, 0, F3_LBU, 0);
        end
        for (int i = 0; i < 16; i += 2) begin
            issue(i, 0, F3_LH, 0);
            issue(i, 0, F3_LHU, 0);
        end
        for (int i = 0; i < 16; i += 4) issue(i, 0, F3_LW, 0);
        drain();

        test_name = "store merge";
        check_lat = 1;
        issue(32'h1, 1, F3_SB, 32'h000000a5);
        issue(32'h6, 1, F3_SH, 32'h0000c3e1);
        issue(32'h8, 1, F3_SW, 32'h87654321);
        issue(32'h0, 0, F3_LW, 0);
        issue(32'h4, 0, F3_LW, 0);
        issue(32'h8, 0, F3_LW, 0);
        issue(32'h1, 0, F3_LB, 0);
        issue(32'h6, 0, F3_LH, 0);
        drain();
        check_lat = 0;

        test_name = "lru eviction";
        issue(32'h100, 0, F3_LW, 0);
        issue(32'h120, 1, F3_SW, 32'hdeadbeef);
        issue(32'h100, 0, F3_LW, 0);
        issue(32'h140, 0, F3_LW, 0);
        drain();
        check("victim writeback address", 32'h120, last_wb_addr);
        issue(32'h120, 0, F3_LW, 0);
        drain();

        test_name = "credit stall";
        issue(32'h310, 1, F3_SW, 32'h11112222);
        issue(32'h330, 1, F3_SW, 32'h33334444);
        drain();
        hold = 1;
        issue(32'h350, 0, F3_LW, 0); // Its writeback credit stays out
        drain();
        issue(32'h370, 0, F3_LW, 0); // Writeback spends the last credit
        watch = 1;
        repeat (30) @(posedge clk);
        check("requests while held", `DC_MEM_CREDITS - 1, held_reqs);
        check("ready while held", 0, ready_while_held);
        watch = 0;
        hold = 0;
        drain();

        test_name = "random mix";
        for (int n = 0; n < 400; n++) begin
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            f3 = r[2:0];
            a = 32'h400 | {25'd0, r[10:4]};
            if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) f3 = F3_LW;
            if (f3[1:0] == 2'b01) a[0] = 1'b0;
            if (f3[1:0] == 2'b10) a[1:0] = 2'b00;
            stim_rng = xorshift(stim_rng);
            if (r[3] && !f3[2]) issue(a, 1, f3, stim_rng);
            else issue(a, 0, f3, 0);
        end
        drain();

        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/dcache_pkg.sv
source/mem_credit_counter.sv
source/dcache_store.sv
source/load_store_align.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verif/dcache_assert.sv
verif/dcache_tb.sv
